// ==== filelist.f ====
hw/simonPkg.sv
hw/blockIf.sv
hw/packetUnpack.sv
hw/keySchedule.sv
hw/roundCore.sv
hw/simonTop.sv
verif/simonTop_assert.sv
verif/simonTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the SIMON testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module simonTb -f filelist.f > build.log 2>&1
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	cat build.log
	echo "Build failed with status $buildStatus"
	exit 1
fi

./obj_dir/VsimonTb > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Testbench reported a failure"
	exit 1
fi

if [ $simStatus -ne 0 ]; then
	echo "Simulation stopped with status $simStatus"
	exit 1
fi

if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

exit 0

// ==== verif/simonTb.sv ====
`timescale 1ns/1ps

module simonTb;
	import simonPkg::*;

	localparam byte_t INFO_OUT = 8'h10;
	localparam byte_t INFO_KEY = 8'h20;
	localparam byte_t INFO_DEC = 8'h40;
	localparam byte_t INFO_TWO = 8'h80;
	localparam int READY_LIMIT = 200;
	localparam int RUN_LIMIT = 200;

	// Standard z0 sequence with its first element in the leftmost bit
	localparam logic [61:0] Z_SEQ = {2{31'b1111101000100101011000011100110}};

	typedef struct packed
	{
		logic [63:0] payload;
		byte_t count;
		byte_t info;
		logic [1:0] nOut;
		errCode_t err;
	} pktEntry_t;

	logic clk;
	logic nR;
	logic pktValid;
	byte_t [PKT_BYTES-1:0] pktBytes;
	logic outValid;
	block_t outBlock;
	byte_t outCount;
	logic outIdx;
	logic errValid;
	errCode_t errCode;
	logic ready;

	pktEntry_t pktTable [$];
	logic [31:0] lcgState;
	key_t curKey;

	simonTop uut
	(
		.clk(clk),
		.nR(nR),
		.pktValid(pktValid),
		.pktBytes(pktBytes),
		.outValid(outValid),
		.outBlock(outBlock),
		.outCount(outCount),
		.outIdx(outIdx),
		.errValid(errValid),
		.errCode(errCode),
		.ready(ready)
	);

	bind simonTop simonTop_assert assertChk
	(
		.clk(clk),
		.nR(nR),
		.pktValid(pktValid),
		.ready(ready),
		.newData(blkBus.newData),
		.loadData(blkBus.loadData),
		.keyReady(keyReady),
		.expanding(expanding)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic word_t rotateLeft(input word_t v, input int s);
		return (v << s) | (v >> (WORD_BITS - s));
	endfunction

	function automatic word_t feistelF(input word_t v);
		return (rotateLeft(v, 1) & rotateLeft(v, 8)) ^ rotateLeft(v, 2);
	endfunction

	// SIMON 32/64 with its own key expansion and the block packed as {x, y}
	function automatic logic [31:0] simonModel(input logic [63:0] keyIn,
		input logic [31:0] blkIn, input logic dec);
		word_t rk [ROUNDS];
		word_t x;
		word_t y;
		word_t t;
		int i;
		for (i = 0; i < KEY_WORDS; i++)
			rk[i] = keyIn[16*i +: 16];
		for (i = KEY_WORDS; i < ROUNDS; i++)
		begin
			// Rotating right by 3 and by 1
			t = rotateLeft(rk[i-1], 13) ^ rk[i-3];
			t = t ^ rotateLeft(t, 15);
			rk[i] = ~rk[i-4] ^ t ^ {15'b0, Z_SEQ[61 - (i - KEY_WORDS)]} ^ 16'h0003;
		end
		x = blkIn[31:16];
		y = blkIn[15:0];
		if (!dec)
		begin
			for (i = 0; i < ROUNDS; i++)
			begin
				t = x;
				x = y ^ feistelF(x) ^ rk[i];
				y = t;
			end
		end
		else
		begin
			for (i = ROUNDS - 1; i >= 0; i--)
			begin
				t = y;
				y = x ^ feistelF(y) ^ rk[i];
				x = t;
			end
		end
		return {x, y};
	endfunction

	function automatic word_t nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[30:15];
	endfunction

	task automatic stopWithFail();
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			stopWithFail();
		end
	endtask

	task automatic abortRun(input string reason);
		$display("Run aborted: %s", reason);
		stopWithFail();
	endtask

	task automatic addEntry(input logic [63:0] payload, input byte_t count, input byte_t info,
		input logic [1:0] nOut, input errCode_t err);
		pktEntry_t e;
		e.payload = payload;
		e.count = count;
		e.info = info;
		e.nOut = nOut;
		e.err = err;
		pktTable.push_back(e);
	endtask

	task automatic buildTable();
		logic [63:0] rnd;
		int i;
		// Key words 0 to 3 sit from the low end of the payload
		addEntry(64'h1918_1110_0908_0100, 8'd0, INFO_KEY, 2'd0, 2'd0);
		addEntry(64'h0000_0000_6565_6877, 8'd1, 8'h00, 2'd1, 2'd0);
		addEntry(64'h0000_0000_c69b_e9bb, 8'd2, INFO_DEC, 2'd1, 2'd0);
		addEntry(64'h0123_4567_89ab_cdef, 8'd3, INFO_TWO, 2'd2, 2'd0);
		addEntry(64'hc69b_e9bb_fedc_ba98, 8'd4, INFO_TWO | INFO_DEC, 2'd2, 2'd0);
		// Count 9 is wrong and the expected count stays at 5
		addEntry(64'h0000_0000_dead_beef, 8'd9, 8'h00, 2'd1, ERR_SEQ);
		addEntry(64'h0000_0000_1357_9bdf, 8'd5, 8'h00, 2'd1, 2'd0);
		addEntry(64'h0000_0000_2468_ace0, 8'd6, 8'h03, 2'd0, ERR_MODE);
		addEntry(64'h0000_0000_0f0f_f0f0, 8'd6, INFO_OUT, 2'd0, ERR_DIR);
		// Mode error wins over the output flag
		addEntry(64'h0000_0000_a5a5_5a5a, 8'd6, INFO_OUT | 8'h05, 2'd0, ERR_MODE);
		rnd = {nextRand(), nextRand(), nextRand(), nextRand()};
		addEntry(rnd, 8'd6, INFO_KEY, 2'd0, 2'd0);
		for (i = 0; i < 20; i++)
		begin
			rnd = {32'h0, nextRand(), nextRand()};
			addEntry(rnd, 8'(7 + i), (i % 2 == 1) ? INFO_DEC : 8'h00, 2'd1, 2'd0);
		end
	endtask

	task automatic waitReady();
		int cycles;
		cycles = 0;
		while (ready !== 1'b1)
		begin
			if (cycles == READY_LIMIT)
				abortRun("ready did not return in time");
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic sendPacket(input pktEntry_t e);
		pktBytes = {e.info, e.count, e.payload};
		pktValid = 1'b1;
		@(negedge clk);
		pktValid = 1'b0;
		pktBytes = '0;
	endtask

	// Samples the strobes each falling edge until ready comes back
	task automatic collectResults(input pktEntry_t e);
		int outCnt;
		int errSeen;
		int cycles;
		logic [31:0] expBlk;
		logic done;
		outCnt = 0;
		errSeen = 0;
		cycles = 0;
		done = 1'b0;
		while (!done)
		begin
			if (errValid === 1'b1)
			begin
				checkValue("errCode", 64'(errCode), 64'(e.err));
				errSeen++;
			end
			if (outValid === 1'b1)
			begin
				if (outCnt >= int'(e.nOut))
					abortRun("outValid came with no block left to expect");
				expBlk = simonModel(curKey, e.payload[32*outCnt +: 32], e.info[6]);
				checkValue("outBlock", 64'(outBlock), 64'(expBlk));
				checkValue("outIdx", 64'(outIdx), 64'(outCnt));
				checkValue("outCount", 64'(outCount), 64'(e.count));
				outCnt++;
			end
			if (ready === 1'b1)
				done = 1'b1;
			else if (cycles == RUN_LIMIT)
				abortRun("packet did not complete in time");
			else
			begin
				@(negedge clk);
				cycles++;
			end
		end
		checkValue("outValid strobes", 64'(outCnt), 64'(e.nOut));
		checkValue("errValid strobes", 64'(errSeen), 64'(e.err != 2'd0));
	endtask

	initial
	begin
		int idx;
		pktEntry_t e;
		nR = 1'b0;
		pktValid = 1'b0;
		pktBytes = '0;
		lcgState = 32'd30083;
		curKey = '0;
		checkValue("model ciphertext",
			64'(simonModel(64'h1918_1110_0908_0100, 32'h6565_6877, 1'b0)), 64'hc69b_e9bb);
		checkValue("model plaintext",
			64'(simonModel(64'h1918_1110_0908_0100, 32'hc69b_e9bb, 1'b1)), 64'h6565_6877);
		buildTable();
		repeat (5) @(negedge clk);
		nR = 1'b1;
		@(negedge clk);
		checkValue("ready after reset", 64'(ready), 64'd1);
		for (idx = 0; idx < pktTable.size(); idx++)
		begin
			e = pktTable[idx];
			waitReady();
			if (e.info[5] && e.err != ERR_MODE && e.err != ERR_DIR)
				curKey = e.payload;
			sendPacket(e);
			collectResults(e);
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== verif/simonTop_assert.sv ====
`timescale 1ns/1ps

module simonTop_assert
(
	input logic clk,
	input logic nR,
	input logic pktValid,
	input logic ready,
	input logic newData,
	input logic loadData,
	input logic keyReady,
	input logic expanding
);

	// The core takes a block only while one is offered and the offer is withdrawn on the next edge
	loadNeedsRequest: assert property (@(posedge clk) disable iff (!nR)
		loadData |-> newData ##1 !newData)
		else $error("loadData seen without newData or newData held after loadData");

	// There is no queue, so a packet may only arrive while the engine is free
	pktOnlyWhenReady: assert property (@(posedge clk) disable iff (!nR)
		pktValid |-> ready)
		else $error("pktValid seen while ready was low");

	// Round keys are not valid until the expansion has finished
	keyHiddenWhileExpanding: assert property (@(posedge clk) disable iff (!nR)
		expanding |-> !keyReady)
		else $error("keyReady seen during key expansion");

endmodule

// ==== hw/simonTop.sv ====
`timescale 1ns/1ps

module simonTop
(
	input logic clk,
	input logic nR,
	input logic pktValid,
	input simonPkg::byte_t [simonPkg::PKT_BYTES-1:0] pktBytes,
	output logic outValid,
	output simonPkg::block_t outBlock,
	output simonPkg::byte_t outCount,
	output logic outIdx,
	output logic errValid,
	output simonPkg::errCode_t errCode,
	output logic ready
);
	import simonPkg::*;

	logic newKey;
	logic loadKey;
	key_t key;
	roundIdx_t roundIdx;
	word_t roundKey;
	logic keyReady;
	logic expanding;
	logic unpackBusy;
	logic coreBusy;

	blockIf blkBus ();

	packetUnpack unpack
	(
		.clk(clk),
		.nR(nR),
		.pktValid(pktValid),
		.pktBytes(pktBytes),
		.newKey(newKey),
		.key(key),
		.loadKey(loadKey),
		.blk(blkBus.source),
		.errValid(errValid),
		.errCode(errCode),
		.busy(unpackBusy)
	);

	keySchedule sched
	(
		.clk(clk),
		.nR(nR),
		.newKey(newKey),
		.key(key),
		.loadKey(loadKey),
		.roundIdx(roundIdx),
		.roundKey(roundKey),
		.keyReady(keyReady),
		.expanding(expanding)
	);

	roundCore core
	(
		.clk(clk),
		.nR(nR),
		.blk(blkBus.sink),
		.keyReady(keyReady),
		.roundIdx(roundIdx),
		.roundKey(roundKey),
		.outValid(outValid),
		.outBlock(outBlock),
		.outCount(outCount),
		.outIdx(outIdx),
		.busy(coreBusy)
	);

	// The source may present a packet only while nothing is in flight
	assign ready = ~(unpackBusy | coreBusy | expanding);

endmodule

// ==== hw/roundCore.sv ====
`timescale 1ns/1ps

module roundCore
(
	input logic clk,
	input logic nR,
	blockIf.sink blk,
	input logic keyReady,
	output simonPkg::roundIdx_t roundIdx,
	input simonPkg::word_t roundKey,
	output logic outValid,
	output simonPkg::block_t outBlock,
	output simonPkg::byte_t outCount,
	output logic outIdx,
	output logic busy
);
	import simonPkg::*;

	word_t x;
	word_t y;
	logic decrypt;
	logic lastRound;

	// f(v) = (v <<< 1 & v <<< 8) ^ v <<< 2
	function automatic word_t roundF(input word_t v);
		return ({v[14:0], v[15]} & {v[7:0], v[15:8]}) ^ {v[13:0], v[15:14]};
	endfunction

	assign blk.loadData = blk.newData & keyReady & ~busy;

	// Decryption walks the keys from the top index down
	assign lastRound = decrypt ? (roundIdx == '0) : (roundIdx == roundIdx_t'(ROUNDS - 1));

	assign outBlock = {x, y};

	always_ff @(posedge clk or negedge nR)
	begin
		if (!nR)
		begin
			busy <= 1'b0;
			outValid <= 1'b0;
			decrypt <= 1'b0;
			roundIdx <= '0;
		end
		else
		begin
			outValid <= 1'b0;
			if (blk.loadData)
			begin
				busy <= 1'b1;
				decrypt <= blk.encDec;
				roundIdx <= blk.encDec ? roundIdx_t'(ROUNDS - 1) : '0;
			end
			else if (busy)
			begin
				if (lastRound)
				begin
					busy <= 1'b0;
					outValid <= 1'b1;
				end
				else if (decrypt)
					roundIdx <= roundIdx - 5'd1;
				else
					roundIdx <= roundIdx + 5'd1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (blk.loadData)
		begin
			{x, y} <= blk.block;
			outIdx <= blk.blockIdx;
			outCount <= blk.count;
		end
		else if (busy)
		begin
			if (decrypt)
			begin
				// Inverse round, x and y trade places
				x <= y;
				y <= x ^ roundF(y) ^ roundKey;
			end
			else
			begin
				x <= y ^ roundF(x) ^ roundKey;
				y <= x;
			end
		end
	end

endmodule

// ==== hw/keySchedule.sv ====
`timescale 1ns/1ps

module keySchedule
(
	input logic clk,
	input logic nR,
	input logic newKey,
	input simonPkg::key_t key,
	output logic loadKey,
	input simonPkg::roundIdx_t roundIdx,
	output simonPkg::word_t roundKey,
	output logic keyReady,
	output logic expanding
);
	import simonPkg::*;

	word_t rk [ROUNDS];
	roundIdx_t idx;
	roundIdx_t back1;
	roundIdx_t back3;
	roundIdx_t back4;
	word_t tmp;
	word_t nextKey;

	// A key is taken whenever no expansion is running
	assign loadKey = newKey & ~expanding;
	assign roundKey = rk[roundIdx];

	assign back1 = idx - 5'd1;
	assign back3 = idx - 5'd3;
	assign back4 = idx - 5'd4;

	// k[i] = c ^ z[i-4] ^ k[i-4] ^ t ^ (t >>> 1), t = (k[i-1] >>> 3) ^ k[i-3]
	assign tmp = {rk[back1][2:0], rk[back1][15:3]} ^ rk[back3];
	assign nextKey = SIMON_C ^ {15'b0, Z0[back4]} ^ rk[back4] ^ tmp ^ {tmp[0], tmp[15:1]};

	always_ff @(posedge clk or negedge nR)
	begin
		if (!nR)
		begin
			idx <= '0;
			expanding <= 1'b0;
			keyReady <= 1'b0;
		end
		else if (loadKey)
		begin
			idx <= roundIdx_t'(KEY_WORDS);
			expanding <= 1'b1;
			keyReady <= 1'b0;
		end
		else if (expanding)
		begin
			idx <= idx + 5'd1;
			if (idx == roundIdx_t'(ROUNDS - 1))
			begin
				expanding <= 1'b0;
				keyReady <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (loadKey)
		begin
			for (int i = 0; i < KEY_WORDS; i++)
				rk[i] <= key[i*WORD_BITS +: WORD_BITS];
		end
		else if (expanding)
		begin
			rk[idx] <= nextKey;
		end
	end

endmodule

// ==== hw/packetUnpack.sv ====
`timescale 1ns/1ps

module packetUnpack
(
	input logic clk,
	input logic nR,
	input logic pktValid,
	input simonPkg::byte_t [simonPkg::PKT_BYTES-1:0] pktBytes,
	output logic newKey,
	output simonPkg::key_t key,
	input logic loadKey,
	blockIf.source blk,
	output logic errValid,
	output simonPkg::errCode_t errCode,
	output logic busy
);
	import simonPkg::*;

	unpackState_t state;
	unpackState_t nextState;

	word_t words [KEY_WORDS];
	byte_t pktCount;
	byte_t info;
	byte_t expCount;
	logic blkSel;

	logic modeBad;
	logic dirBad;
	logic seqBad;
	logic drop;
	logic accepted;

	assign modeBad = info[3:0] != MODE_ID;
	assign dirBad = info[4];
	assign seqBad = pktCount != expCount;
	assign drop = modeBad | dirBad;
	assign accepted = (newKey & loadKey) | (blk.newData & blk.loadData);

	assign busy = state != IDLE;

	always_comb
	begin
		nextState = state;
		case (state)
			IDLE:
				if (pktValid)
					nextState = CHECK;
			CHECK:
				nextState = drop ? IDLE : WRITE;
			WRITE:
				nextState = HOLD;
			HOLD:
			begin
				// A second block follows only for two-block data packets
				if (accepted)
					nextState = (info[7] && !info[5] && !blkSel) ? WRITE : IDLE;
			end
			default:
				nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge nR)
	begin
		if (!nR)
		begin
			state <= IDLE;
			newKey <= 1'b0;
			blk.newData <= 1'b0;
			errValid <= 1'b0;
			errCode <= '0;
			expCount <= '0;
			blkSel <= 1'b0;
		end
		else
		begin
			state <= nextState;
			errValid <= 1'b0;
			case (state)
				CHECK:
				begin
					errValid <= drop | seqBad;
					if (modeBad)
						errCode <= ERR_MODE;
					else if (dirBad)
						errCode <= ERR_DIR;
					else
						errCode <= ERR_SEQ;
					// Expected count moves on only for a matching, kept packet
					if (!drop && !seqBad)
						expCount <= expCount + 8'd1;
					blkSel <= 1'b0;
				end
				WRITE:
				begin
					if (info[5])
						newKey <= 1'b1;
					else
						blk.newData <= 1'b1;
				end
				HOLD:
				begin
					if (accepted)
					begin
						newKey <= 1'b0;
						blk.newData <= 1'b0;
						blkSel <= 1'b1;
					end
				end
				default:
				begin
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == IDLE && pktValid)
		begin
			for (int w = 0; w < KEY_WORDS; w++)
				words[w] <= {pktBytes[2*w+1], pktBytes[2*w]};
			pktCount <= pktBytes[8];
			info <= pktBytes[9];
		end
		if (state == WRITE)
		begin
			key <= {words[3], words[2], words[1], words[0]};
			// Block b is x = word 2b+1, y = word 2b
			blk.block <= {words[{blkSel, 1'b1}], words[{blkSel, 1'b0}]};
			blk.encDec <= info[6];
			blk.blockIdx <= blkSel;
			blk.count <= pktCount;
		end
	end

endmodule

// ==== hw/blockIf.sv ====
`timescale 1ns/1ps

interface blockIf;
	import simonPkg::*;

	// Request held high until the cycle loadData is seen
	logic newData;
	// High selects decryption
	logic encDec;
	block_t block;
	logic blockIdx;
	// Packet count byte travelling with the block
	byte_t count;
	logic loadData;

	modport source
	(
		output newData, encDec, block, blockIdx, count,
		input loadData
	);

	modport sink
	(
		input newData, encDec, block, blockIdx, count,
		output loadData
	);

endinterface

// ==== hw/simonPkg.sv ====
package simonPkg;

	// SIMON 32/64 sizes
	localparam int WORD_BITS = 16;
	localparam int KEY_WORDS = 4;
	localparam int ROUNDS = 32;
	localparam int PKT_BYTES = 10;

	// Only packets carrying this mode in info[3:0] are accepted
	localparam logic [3:0] MODE_ID = 4'd0;

	// Element j of the z0 sequence sits at bit j
	localparam logic [61:0] Z0 = 62'b01100111000011010100100010111110110011100001101010010001011111;

	// One cipher word
	typedef logic [WORD_BITS-1:0] word_t;

	// Upper word is x, lower word is y
	typedef logic [2*WORD_BITS-1:0] block_t;

	// Word 0 in the lowest bits, used first by the schedule
	typedef logic [KEY_WORDS*WORD_BITS-1:0] key_t;

	typedef logic [7:0] byte_t;

	typedef logic [4:0] roundIdx_t;

	typedef logic [1:0] errCode_t;

	// Round constant of the key recurrence, 2^n - 4
	localparam word_t SIMON_C = 16'hfffc;

	// Count mismatch, packet still processed
	localparam errCode_t ERR_SEQ = 2'd1;
	// Wrong mode, packet dropped
	localparam errCode_t ERR_MODE = 2'd2;
	// Output flag seen at the input, packet dropped
	localparam errCode_t ERR_DIR = 2'd3;

	typedef enum logic [1:0]
	{
		IDLE,
		CHECK,
		WRITE,
		HOLD
	} unpackState_t;

endpackage
